//--- l1_pkg.sv
//////////////////////////////////////////////////
// Shared types for the level-one memory front end
// Strand, unit, bus operation and bus master state
// definitions used by the RTL and the testbench
//////////////////////////////////////////////////

package l1_pkg;

	// Default strand count of the core
	localparam int NUM_STRANDS_DEF = 4;

	// Default word address width on the L2 port
	localparam int ADDR_W_DEF = 16;

	// One data word and its byte selects
	localparam int WORD_W = 32;
	localparam int SEL_W = 4;

	// Strand index, sized for the default strand count
	typedef logic [1:0] strand_t;

	// Which unit sent a request to the L2 port
	typedef enum logic
	{
		UNIT_STBUF,
		UNIT_LOADQ
	} unit_e;

	// Operation carried by one L2 request
	// Both store kinds are writes on the bus
	typedef enum logic [1:0]
	{
		L2_LOAD,
		L2_STORE,
		L2_STORE_SYNC
	} l2_op_e;

	// Bus master sequence
	// IDLE takes a request, BUS waits for ack or err, RESP pulses the response
	typedef enum logic [1:0]
	{
		IDLE,
		BUS,
		RESP
	} wb_state_e;

endpackage

//--- l2_req_if.sv
//////////////////////////////////////////////////
// Request and response channel between one unit
// and the L2 port arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface l2_req_if import l1_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF
);

	// Request side, driven by the unit
	logic req_valid;
	l2_op_e op;
	strand_t strand;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] data;
	logic [SEL_W-1:0] sel;

	// Handshake and response, driven by the arbiter
	// rsp_status is 1 for ack and 0 for err
	logic req_ready;
	logic rsp_valid;
	strand_t rsp_strand;
	logic rsp_status;
	logic [WORD_W-1:0] rsp_data;

	modport requester (
		output req_valid, op, strand, addr, data, sel,
		input req_ready, rsp_valid, rsp_strand, rsp_status, rsp_data
	);

	modport arbiter (
		input req_valid, op, strand, addr, data, sel,
		output req_ready, rsp_valid, rsp_strand, rsp_status, rsp_data
	);

endinterface

//--- rr_arbiter.sv
//////////////////////////////////////////////////
// Round-robin arbiter with a one-hot grant
// Priority moves past the last accepted grant
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rr_arbiter #(
	parameter int NUM_ENTRIES = 4
) (
	input logic clk,
	input logic reset,
	input logic [NUM_ENTRIES-1:0] request_i,
	input logic update_i,
	output logic [NUM_ENTRIES-1:0] grant_o
);

	localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

	// Index of the entry granted last
	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] grant_idx;

	// Scan the entries starting just after the last winner, wrapping around
	always_comb
	begin
		int idx;
		logic found;
		grant_o = '0;
		grant_idx = last_q;
		found = 1'b0;
		for (int k = 1; k <= NUM_ENTRIES; k++)
		begin
			idx = (int'(last_q) + k) % NUM_ENTRIES;
			if (!found && request_i[idx])
			begin
				grant_o[idx] = 1'b1;
				grant_idx = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	// Starting at the top index makes entry 0 the first winner after reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			last_q <= IDX_W'(NUM_ENTRIES - 1);
		else if (update_i && |grant_o)
			last_q <= grant_idx;
	end

endmodule

//--- store_buffer.sv
//////////////////////////////////////////////////
// Store buffer with one pending store per strand
// Bypasses pending data to loads of the same strand,
// rolls back and resumes strands, tracks sync stores
//////////////////////////////////////////////////

`timescale 1ns/1ps

module store_buffer import l1_pkg::*; #(
	parameter int NUM_STRANDS = NUM_STRANDS_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic reset,
	input strand_t strand_i,
	input logic [ADDR_W-1:0] addr_i,
	input logic [WORD_W-1:0] data_i,
	input logic [SEL_W-1:0] sel_i,
	input logic store_i,
	input logic sync_i,
	input logic stbar_i,
	output logic [WORD_W-1:0] bypass_data_o,
	output logic [SEL_W-1:0] bypass_mask_o,
	output logic rollback_o,
	output logic [NUM_STRANDS-1:0] resume_o,
	l2_req_if.requester l2
);

	// Entry control flags, one bit per strand
	logic [NUM_STRANDS-1:0] enq_q;
	logic [NUM_STRANDS-1:0] issued_q;

	// Entry payload
	logic [ADDR_W-1:0] addr_q [NUM_STRANDS];
	logic [WORD_W-1:0] data_q [NUM_STRANDS];
	logic [SEL_W-1:0] sel_q [NUM_STRANDS];
	l2_op_e op_q [NUM_STRANDS];

	// Strands parked by a full entry or a barrier
	logic [NUM_STRANDS-1:0] wait_q;

	// Sync stores waiting for the bus, their ready results and the result bits
	logic [NUM_STRANDS-1:0] sync_wait_q;
	logic [NUM_STRANDS-1:0] sync_done_q;
	logic [NUM_STRANDS-1:0] sync_result_q;

	logic [NUM_STRANDS-1:0] issue_oh;
	strand_t issue_idx;
	logic [NUM_STRANDS-1:0] req_mask;
	logic [NUM_STRANDS-1:0] finish_mask;
	logic [NUM_STRANDS-1:0] sync_req_mask;
	logic request;
	logic store_done;
	logic collision;
	logic must_wait;
	logic need_sync_rollback;

	// Pick the next entry that holds a store not yet sent to the bus
	rr_arbiter #(
		.NUM_ENTRIES(NUM_STRANDS)
	) u_issue_arb (
		.clk(clk),
		.reset(reset),
		.request_i(enq_q & ~issued_q),
		.update_i(l2.req_ready),
		.grant_o(issue_oh)
	);

	always_comb
	begin
		issue_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
			if (issue_oh[i])
				issue_idx = strand_t'(i);
	end

	assign l2.req_valid = |issue_oh;
	assign l2.op = op_q[issue_idx];
	assign l2.strand = issue_idx;
	assign l2.addr = addr_q[issue_idx];
	assign l2.data = data_q[issue_idx];
	assign l2.sel = sel_q[issue_idx];

	assign request = store_i || stbar_i;
	assign req_mask = NUM_STRANDS'(1) << strand_i;
	assign finish_mask = l2.rsp_valid ? (NUM_STRANDS'(1) << l2.rsp_strand) : '0;
	assign store_done = l2.rsp_valid && enq_q[l2.rsp_strand];

	// A request that meets the response freeing its own entry must not park,
	// since no later response would wake the strand up again
	assign collision = store_done && request && (strand_i == l2.rsp_strand);
	assign must_wait = request && enq_q[strand_i] && !collision;

	// A sync store with no finished result goes to the bus and rolls back
	assign sync_req_mask = (sync_i && store_i && !enq_q[strand_i]) ? req_mask : '0;
	assign need_sync_rollback = |(sync_req_mask & ~sync_done_q);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			enq_q <= '0;
			issued_q <= '0;
			wait_q <= '0;
			sync_wait_q <= '0;
			sync_done_q <= '0;
			rollback_o <= 1'b0;
			resume_o <= '0;
			bypass_data_o <= '0;
			bypass_mask_o <= '0;
		end
		else
		begin
			rollback_o <= must_wait || need_sync_rollback;
			wait_q <= (wait_q & ~finish_mask) | (must_wait ? req_mask : '0);

			// Resume one cycle after the response, so it always lands after the rollback
			resume_o <= finish_mask & (wait_q | sync_wait_q);

			// Sync re-issue gets its result bit, otherwise same-strand bypass
			if (sync_i && store_i)
			begin
				bypass_mask_o <= '1;
				bypass_data_o <= {{(WORD_W - 1){1'b0}}, sync_result_q[strand_i]};
			end
			else if (enq_q[strand_i] && addr_q[strand_i] == addr_i)
			begin
				bypass_mask_o <= sel_q[strand_i];
				bypass_data_o <= data_q[strand_i];
			end
			else
			begin
				bypass_mask_o <= '0;
				bypass_data_o <= '0;
			end

			if (store_i && (!enq_q[strand_i] || collision) && (!sync_i || need_sync_rollback))
				enq_q[strand_i] <= 1'b1;

			if (l2.req_valid && l2.req_ready)
				issued_q[issue_idx] <= 1'b1;

			// A colliding store keeps the entry and is sent again as new
			if (store_done)
			begin
				if (!collision)
					enq_q[l2.rsp_strand] <= 1'b0;
				issued_q[l2.rsp_strand] <= 1'b0;
			end

			sync_wait_q <= (sync_wait_q | (sync_req_mask & ~sync_done_q)) & ~finish_mask;
			sync_done_q <= (sync_done_q | (sync_wait_q & finish_mask)) & ~sync_req_mask;
		end
	end

	// Entry payload and the sync result bit
	always_ff @(posedge clk)
	begin
		if (store_i && (!enq_q[strand_i] || collision) && (!sync_i || need_sync_rollback))
		begin
			addr_q[strand_i] <= addr_i;
			data_q[strand_i] <= data_i;
			sel_q[strand_i] <= sel_i;
			op_q[strand_i] <= sync_i ? L2_STORE_SYNC : L2_STORE;
		end
		if (|(finish_mask & sync_wait_q))
			sync_result_q[l2.rsp_strand] <= l2.rsp_status;
	end

endmodule

//--- load_miss_unit.sv
//////////////////////////////////////////////////
// Load miss unit with one pending load per strand
// Sends loads as bus reads, returns data by strand
//////////////////////////////////////////////////

`timescale 1ns/1ps

module load_miss_unit import l1_pkg::*; #(
	parameter int NUM_STRANDS = NUM_STRANDS_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic reset,
	input strand_t strand_i,
	input logic [ADDR_W-1:0] addr_i,
	input logic load_i,
	output logic load_rollback_o,
	output logic load_valid_o,
	output strand_t load_strand_o,
	output logic [WORD_W-1:0] load_data_o,
	l2_req_if.requester l2
);

	logic [NUM_STRANDS-1:0] pend_q;
	logic [NUM_STRANDS-1:0] issued_q;
	logic [ADDR_W-1:0] addr_q [NUM_STRANDS];

	logic [NUM_STRANDS-1:0] issue_oh;
	strand_t issue_idx;
	logic done_same;
	logic accept;

	rr_arbiter #(
		.NUM_ENTRIES(NUM_STRANDS)
	) u_issue_arb (
		.clk(clk),
		.reset(reset),
		.request_i(pend_q & ~issued_q),
		.update_i(l2.req_ready),
		.grant_o(issue_oh)
	);

	always_comb
	begin
		issue_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
			if (issue_oh[i])
				issue_idx = strand_t'(i);
	end

	// Loads always read a full word
	assign l2.req_valid = |issue_oh;
	assign l2.op = L2_LOAD;
	assign l2.strand = issue_idx;
	assign l2.addr = addr_q[issue_idx];
	assign l2.data = '0;
	assign l2.sel = '1;

	// The response that frees the entry also takes a new load for that strand
	assign done_same = l2.rsp_valid && (l2.rsp_strand == strand_i);
	assign accept = load_i && (!pend_q[strand_i] || done_same);

	// Returned data goes to the core in the response cycle
	assign load_valid_o = l2.rsp_valid;
	assign load_strand_o = l2.rsp_strand;
	assign load_data_o = l2.rsp_data;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pend_q <= '0;
			issued_q <= '0;
			load_rollback_o <= 1'b0;
		end
		else
		begin
			load_rollback_o <= load_i && !accept;
			if (l2.req_valid && l2.req_ready)
				issued_q[issue_idx] <= 1'b1;
			if (l2.rsp_valid)
			begin
				pend_q[l2.rsp_strand] <= 1'b0;
				issued_q[l2.rsp_strand] <= 1'b0;
			end
			if (accept)
				pend_q[strand_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			addr_q[strand_i] <= addr_i;
	end

endmodule

//--- l2_wb_master.sv
//////////////////////////////////////////////////
// L2 port arbiter and Wishbone classic master
// Runs one bus cycle per request and routes the
// response back to the unit that asked
//////////////////////////////////////////////////

`timescale 1ns/1ps

module l2_wb_master import l1_pkg::*; #(
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic reset,
	l2_req_if.arbiter st,
	l2_req_if.arbiter ld,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output logic [ADDR_W-1:0] wb_adr_o,
	output logic [WORD_W-1:0] wb_dat_o,
	output logic [SEL_W-1:0] wb_sel_o,
	input logic [WORD_W-1:0] wb_dat_i,
	input logic wb_ack_i,
	input logic wb_err_i
);

	wb_state_e state_q;
	logic [1:0] grant;
	logic take;

	// Request latched for the bus cycle
	unit_e unit_q;
	strand_t strand_q;
	logic we_q;
	logic [ADDR_W-1:0] adr_q;
	logic [WORD_W-1:0] dat_q;
	logic [SEL_W-1:0] sel_q;

	// Response latched when the slave ends the cycle
	logic status_q;
	logic [WORD_W-1:0] rdata_q;

	// Bit 0 is the store buffer, bit 1 the load miss unit
	rr_arbiter #(
		.NUM_ENTRIES(2)
	) u_port_arb (
		.clk(clk),
		.reset(reset),
		.request_i({ld.req_valid, st.req_valid}),
		.update_i(state_q == IDLE),
		.grant_o(grant)
	);

	assign take = (state_q == IDLE) && |grant;
	assign st.req_ready = (state_q == IDLE) && grant[0];
	assign ld.req_ready = (state_q == IDLE) && grant[1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state_q <= IDLE;
		else
			case (state_q)
				IDLE: if (take) state_q <= BUS;
				BUS: if (wb_ack_i || wb_err_i) state_q <= RESP;
				default: state_q <= IDLE;
			endcase
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			unit_q <= grant[1] ? UNIT_LOADQ : UNIT_STBUF;
			strand_q <= grant[1] ? ld.strand : st.strand;
			we_q <= grant[1] ? (ld.op != L2_LOAD) : (st.op != L2_LOAD);
			adr_q <= grant[1] ? ld.addr : st.addr;
			dat_q <= grant[1] ? ld.data : st.data;
			sel_q <= grant[1] ? ld.sel : st.sel;
		end
		// Status is 1 on ack and 0 on err
		if (state_q == BUS && (wb_ack_i || wb_err_i))
		begin
			status_q <= wb_ack_i;
			rdata_q <= wb_dat_i;
		end
	end

	// Bus signals stay steady for the whole of BUS
	assign wb_cyc_o = (state_q == BUS);
	assign wb_stb_o = (state_q == BUS);
	assign wb_we_o = we_q;
	assign wb_adr_o = adr_q;
	assign wb_dat_o = dat_q;
	assign wb_sel_o = sel_q;

	// One response pulse, only on the side that issued
	assign st.rsp_valid = (state_q == RESP) && (unit_q == UNIT_STBUF);
	assign ld.rsp_valid = (state_q == RESP) && (unit_q == UNIT_LOADQ);
	assign st.rsp_strand = strand_q;
	assign ld.rsp_strand = strand_q;
	assign st.rsp_status = status_q;
	assign ld.rsp_status = status_q;
	assign st.rsp_data = rdata_q;
	assign ld.rsp_data = rdata_q;

endmodule

//--- l1_mem_top.sv
//////////////////////////////////////////////////
// Level-one memory front end top level
// Store buffer and load miss unit sharing one
// Wishbone master port toward the L2
//////////////////////////////////////////////////

`timescale 1ns/1ps

module l1_mem_top import l1_pkg::*; #(
	parameter int NUM_STRANDS = NUM_STRANDS_DEF,
	parameter int ADDR_W = ADDR_W_DEF
) (
	input logic clk,
	input logic reset,
	input strand_t strand_i,
	input logic [ADDR_W-1:0] addr_i,
	input logic [WORD_W-1:0] data_i,
	input logic [SEL_W-1:0] sel_i,
	input logic store_i,
	input logic sync_i,
	input logic stbar_i,
	input logic load_i,
	output logic [WORD_W-1:0] bypass_data_o,
	output logic [SEL_W-1:0] bypass_mask_o,
	output logic rollback_o,
	output logic [NUM_STRANDS-1:0] resume_o,
	output logic load_rollback_o,
	output logic load_valid_o,
	output strand_t load_strand_o,
	output logic [WORD_W-1:0] load_data_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output logic [ADDR_W-1:0] wb_adr_o,
	output logic [WORD_W-1:0] wb_dat_o,
	output logic [SEL_W-1:0] wb_sel_o,
	input logic [WORD_W-1:0] wb_dat_i,
	input logic wb_ack_i,
	input logic wb_err_i
);

	// One channel per requesting unit
	l2_req_if #(.ADDR_W(ADDR_W)) st_if ();
	l2_req_if #(.ADDR_W(ADDR_W)) ld_if ();

	store_buffer #(
		.NUM_STRANDS(NUM_STRANDS),
		.ADDR_W(ADDR_W)
	) u_store_buffer (
		.clk(clk),
		.reset(reset),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.data_i(data_i),
		.sel_i(sel_i),
		.store_i(store_i),
		.sync_i(sync_i),
		.stbar_i(stbar_i),
		.bypass_data_o(bypass_data_o),
		.bypass_mask_o(bypass_mask_o),
		.rollback_o(rollback_o),
		.resume_o(resume_o),
		.l2(st_if)
	);

	load_miss_unit #(
		.NUM_STRANDS(NUM_STRANDS),
		.ADDR_W(ADDR_W)
	) u_load_miss_unit (
		.clk(clk),
		.reset(reset),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.load_i(load_i),
		.load_rollback_o(load_rollback_o),
		.load_valid_o(load_valid_o),
		.load_strand_o(load_strand_o),
		.load_data_o(load_data_o),
		.l2(ld_if)
	);

	l2_wb_master #(
		.ADDR_W(ADDR_W)
	) u_l2_wb_master (
		.clk(clk),
		.reset(reset),
		.st(st_if),
		.ld(ld_if),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o),
		.wb_sel_o(wb_sel_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i),
		.wb_err_i(wb_err_i)
	);

endmodule

//--- tb_l1_mem.sv
//////////////////////////////////////////////////
// Testbench for the level-one memory front end
// Wishbone memory model with random wait states,
// stimulus and expected values from a golden file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_l1_mem import l1_pkg::*; ();

	localparam int MAX_ROWS = 64;
	localparam int COLS = 7;
	localparam int LOOP_LIMIT = 200;

	// Operation codes used in the golden file
	localparam int OP_ST = 1;
	localparam int OP_LD = 2;
	localparam int OP_LDW = 3;
	localparam int OP_BYP = 4;
	localparam int OP_RTRY = 5;
	localparam int OP_SYNC = 6;
	localparam int OP_DRAIN = 7;
	localparam int OP_MEM = 8;

	logic clk;
	logic reset;
	strand_t strand;
	logic [ADDR_W_DEF-1:0] addr;
	logic [WORD_W-1:0] data;
	logic [SEL_W-1:0] sel;
	logic store;
	logic sync;
	logic stbar;
	logic load;
	logic [WORD_W-1:0] bypass_data;
	logic [SEL_W-1:0] bypass_mask;
	logic rollback;
	logic [NUM_STRANDS_DEF-1:0] resume;
	logic load_rollback;
	logic load_valid;
	strand_t load_strand;
	logic [WORD_W-1:0] load_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADDR_W_DEF-1:0] wb_adr;
	logic [WORD_W-1:0] wb_dat_w;
	logic [SEL_W-1:0] wb_sel;
	logic [WORD_W-1:0] wb_dat_r;
	logic wb_ack;
	logic wb_err;

	// Expected rollback for the cycle being driven, and its copy one cycle later
	logic rb_chk;
	logic rb_exp;
	logic lrb_chk;
	logic lrb_exp;
	logic rb_chk_d;
	logic rb_exp_d;
	logic lrb_chk_d;
	logic lrb_exp_d;

	// Wishbone slave memory and its wait counter
	logic [WORD_W-1:0] mem [64];
	logic [2:0] delay;
	integer seed = 32'hf4f8_5c75;

	logic [31:0] vec [MAX_ROWS*COLS];
	int n_rows = 0;
	int err_cnt = 0;
	int pass_tests = 0;
	int fail_tests = 0;
	logic test_bad = 1'b0;

	l1_mem_top #(
		.NUM_STRANDS(NUM_STRANDS_DEF),
		.ADDR_W(ADDR_W_DEF)
	) DUT (
		.clk(clk),
		.reset(reset),
		.strand_i(strand),
		.addr_i(addr),
		.data_i(data),
		.sel_i(sel),
		.store_i(store),
		.sync_i(sync),
		.stbar_i(stbar),
		.load_i(load),
		.bypass_data_o(bypass_data),
		.bypass_mask_o(bypass_mask),
		.rollback_o(rollback),
		.resume_o(resume),
		.load_rollback_o(load_rollback),
		.load_valid_o(load_valid),
		.load_strand_o(load_strand),
		.load_data_o(load_data),
		.wb_cyc_o(wb_cyc),
		.wb_stb_o(wb_stb),
		.wb_we_o(wb_we),
		.wb_adr_o(wb_adr),
		.wb_dat_o(wb_dat_w),
		.wb_sel_o(wb_sel),
		.wb_dat_i(wb_dat_r),
		.wb_ack_i(wb_ack),
		.wb_err_i(wb_err)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Memory model, filled with a pattern of the word index on reset
	// Each bus cycle waits 1 to 4 cycles, then acks, or errs when address bit 15 is set
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			wb_dat_r <= '0;
			delay <= '0;
			for (int i = 0; i < 64; i++)
				mem[i] <= i * 32'h0101_0101;
		end
		else
		begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack && !wb_err)
			begin
				if (delay == 0)
					delay <= 3'd1 + 3'($unsigned($random(seed)) % 4);
				else if (delay == 1)
				begin
					delay <= '0;
					if (wb_adr[15])
						wb_err <= 1'b1;
					else
					begin
						wb_ack <= 1'b1;
						wb_dat_r <= mem[wb_adr[5:0]];
						// Writes merge byte by byte under the select
						for (int b = 0; b < SEL_W; b++)
							if (wb_we && wb_sel[b])
								mem[wb_adr[5:0]][8*b +: 8] <= wb_dat_w[8*b +: 8];
					end
				end
				else
					delay <= delay - 3'd1;
			end
		end
	end

	task automatic note_fail();
		err_cnt++;
		test_bad = 1'b1;
	endtask

	// Rollbacks are registered, so compare them one cycle after the request
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rb_chk_d <= 1'b0;
			rb_exp_d <= 1'b0;
			lrb_chk_d <= 1'b0;
			lrb_exp_d <= 1'b0;
		end
		else
		begin
			rb_chk_d <= rb_chk;
			rb_exp_d <= rb_exp;
			lrb_chk_d <= lrb_chk;
			lrb_exp_d <= lrb_exp;
		end
	end

	// Without a request in the previous cycle both rollbacks must stay low
	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (rollback === (rb_chk_d && rb_exp_d))
			else
			begin
				$display("FAIL %0t: rollback_o is %b, expected %b", $time, rollback,
					rb_chk_d && rb_exp_d);
				note_fail();
			end
			assert (load_rollback === (lrb_chk_d && lrb_exp_d))
			else
			begin
				$display("FAIL %0t: load_rollback_o is %b, expected %b", $time, load_rollback,
					lrb_chk_d && lrb_exp_d);
				note_fail();
			end
		end
	end

	task automatic drive_core(input logic st_en, input logic sy_en, input logic ld_en,
		input strand_t s, input logic [15:0] a, input logic [31:0] d, input logic [3:0] m,
		input logic rb_e, input logic lrb_e);
		strand <= s;
		addr <= a;
		data <= d;
		sel <= m;
		store <= st_en;
		sync <= sy_en;
		stbar <= 1'b0;
		load <= ld_en;
		rb_chk <= st_en;
		rb_exp <= rb_e;
		lrb_chk <= ld_en;
		lrb_exp <= lrb_e;
	endtask

	task automatic drive_idle();
		drive_core(1'b0, 1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	// Wait for the resume pulse of one strand
	task automatic wait_resume(input strand_t s);
		int n;
		n = 0;
		@(negedge clk);
		while (!resume[s] && n < LOOP_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!resume[s])
		begin
			$display("timeout: strand %0d was never resumed", s);
			note_fail();
		end
	endtask

	task automatic wait_load(input strand_t s, output logic [WORD_W-1:0] d);
		int n;
		n = 0;
		d = 'x;
		@(negedge clk);
		while (!(load_valid && load_strand == s) && n < LOOP_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (load_valid && load_strand == s)
			d = load_data;
		else
		begin
			$display("timeout: no load data came back for strand %0d", s);
			note_fail();
		end
	endtask

	// The bus counts as drained once it has stayed idle for six cycles
	task automatic drain_bus();
		int idle_cnt;
		int n;
		idle_cnt = 0;
		n = 0;
		@(posedge clk);
		drive_idle();
		while (idle_cnt < 6 && n < LOOP_LIMIT)
		begin
			@(negedge clk);
			n++;
			if (wb_cyc)
				idle_cnt = 0;
			else
				idle_cnt++;
		end
		if (idle_cnt < 6)
		begin
			$display("timeout: the bus never went idle");
			note_fail();
		end
	endtask

	task automatic check_bypass(input logic [3:0] m, input logic [31:0] e);
		assert (bypass_mask === m && bypass_data === e)
		else
		begin
			$display("FAIL %0t: bypass mask %h data %h, expected mask %h data %h", $time,
				bypass_mask, bypass_data, m, e);
			note_fail();
		end
	endtask

	task automatic report_test(input int t);
		if (test_bad)
		begin
			fail_tests++;
			$display("test %0d: failed", t);
		end
		else
		begin
			pass_tests++;
			$display("test %0d: passed", t);
		end
		test_bad = 1'b0;
	endtask

	// Bound the run by the length of the golden file
	initial
	begin
		wait (n_rows > 0);
		repeat (n_rows * 40) @(posedge clk);
		$display("watchdog: the run hung and was stopped after %0d cycles", n_rows * 40);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		int rows;
		int t;
		int cur_test;
		int op;
		strand_t s;
		logic [15:0] a;
		logic [31:0] d;
		logic [3:0] m;
		logic [31:0] e;
		logic [31:0] got;
		reset = 1'b1;
		strand = '0;
		addr = '0;
		data = '0;
		sel = '0;
		store = 1'b0;
		sync = 1'b0;
		stbar = 1'b0;
		load = 1'b0;
		rb_chk = 1'b0;
		rb_exp = 1'b0;
		lrb_chk = 1'b0;
		lrb_exp = 1'b0;
		cur_test = 0;

		// Unused rows keep all ones, which marks the end of the file
		for (int i = 0; i < MAX_ROWS * COLS; i++)
			vec[i] = '1;
		$readmemh("l1_mem_golden.txt", vec);
		rows = 0;
		while (rows < MAX_ROWS && vec[rows * COLS] !== 32'hffff_ffff)
			rows++;
		n_rows = rows;

		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert ({rollback, load_rollback, resume, load_valid, wb_cyc, wb_stb} === '0)
		else
		begin
			$display("FAIL %0t: outputs are not low after reset", $time);
			note_fail();
		end

		for (int r = 0; r < n_rows; r++)
		begin
			t = vec[r * COLS];
			op = vec[r * COLS + 1];
			s = strand_t'(vec[r * COLS + 2]);
			a = vec[r * COLS + 3][15:0];
			d = vec[r * COLS + 4];
			m = vec[r * COLS + 5][3:0];
			e = vec[r * COLS + 6];
			if (r > 0 && t != cur_test)
				report_test(cur_test);
			cur_test = t;
			case (op)
				OP_ST:
				begin
					@(posedge clk);
					drive_core(1'b1, 1'b0, 1'b0, s, a, d, m, e[0], 1'b0);
				end
				OP_LD:
				begin
					@(posedge clk);
					drive_core(1'b0, 1'b0, 1'b1, s, a, '0, '0, 1'b0, e[0]);
				end
				OP_LDW:
				begin
					@(posedge clk);
					drive_idle();
					wait_load(s, got);
					assert (got === e)
					else
					begin
						$display("FAIL %0t: strand %0d loaded %h, expected %h", $time, s, got, e);
						note_fail();
					end
				end
				OP_BYP:
				begin
					@(posedge clk);
					drive_core(1'b0, 1'b0, 1'b1, s, a, '0, '0, 1'b0, 1'b0);
					@(posedge clk);
					drive_idle();
					@(negedge clk);
					check_bypass(m, e);
				end
				OP_RTRY:
				begin
					// First issue hits the pending entry, the re-issue after resume is taken
					@(posedge clk);
					drive_core(1'b1, 1'b0, 1'b0, s, a, d, m, 1'b1, 1'b0);
					@(posedge clk);
					drive_idle();
					wait_resume(s);
					@(posedge clk);
					drive_core(1'b1, 1'b0, 1'b0, s, a, d, m, 1'b0, 1'b0);
				end
				OP_SYNC:
				begin
					@(posedge clk);
					drive_core(1'b1, 1'b1, 1'b0, s, a, d, m, 1'b1, 1'b0);
					@(posedge clk);
					drive_idle();
					wait_resume(s);
					@(posedge clk);
					drive_core(1'b1, 1'b1, 1'b0, s, a, d, m, 1'b0, 1'b0);
					@(posedge clk);
					drive_idle();
					@(negedge clk);
					// Result bit comes back with the full mask
					check_bypass(4'hf, e);
				end
				OP_DRAIN:
					drain_bus();
				OP_MEM:
				begin
					@(posedge clk);
					drive_idle();
					@(negedge clk);
					assert (mem[a[5:0]] === e)
					else
					begin
						$display("FAIL %0t: memory at %h holds %h, expected %h", $time, a,
							mem[a[5:0]], e);
						note_fail();
					end
				end
				default:
				begin
					$display("golden file row %0d has an unknown operation %0d", r, op);
					note_fail();
				end
			endcase
		end
		@(posedge clk);
		drive_idle();
		if (n_rows > 0)
			report_test(cur_test);
		else
		begin
			$display("the golden file held no rows");
			err_cnt++;
		end

		$display("summary: %0d tests passed, %0d tests failed, %0d errors", pass_tests,
			fail_tests, err_cnt);
		if (fail_tests == 0 && err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- l1_mem_golden.txt
// Columns: test, op, strand, word address, data, byte select, expected value
// Ops: 1 store, 2 load, 3 load data, 4 bypass, 5 store retry, 6 sync, 7 drain, 8 memory
1 1 0 0004 aabbccdd 5 0
1 7 0 0000 00000000 0 0
1 2 1 0004 00000000 0 0
1 3 1 0004 00000000 0 04bb04dd
1 8 0 0004 00000000 0 04bb04dd
2 1 2 0008 11223344 3 0
2 4 2 0008 00000000 3 11223344
2 3 2 0008 00000000 0 08083344
2 7 0 0000 00000000 0 0
2 1 3 0009 55667788 c 0
2 4 0 0009 00000000 0 00000000
2 3 0 0009 00000000 0 55660909
3 7 0 0000 00000000 0 0
3 1 1 0010 deadbeef f 0
3 5 1 0011 cafef00d f 1
3 7 0 0000 00000000 0 0
3 8 0 0010 00000000 0 deadbeef
3 8 0 0011 00000000 0 cafef00d
4 6 2 0014 12345678 f 1
4 7 0 0000 00000000 0 0
4 8 0 0014 00000000 0 12345678
4 6 3 8015 87654321 f 0
4 7 0 0000 00000000 0 0
4 8 0 8015 00000000 0 15151515
5 1 0 0020 a0a0a0a0 f 0
5 1 1 0021 b1b1b1b1 3 0
5 1 2 0022 c2c2c2c2 c 0
5 1 3 0023 d3d3d3d3 6 0
5 7 0 0000 00000000 0 0
5 8 0 0020 00000000 0 a0a0a0a0
5 8 0 0021 00000000 0 2121b1b1
5 8 0 0022 00000000 0 c2c22222
5 8 0 0023 00000000 0 23d3d323
6 2 1 0030 00000000 0 0
6 2 1 0031 00000000 0 1
6 3 1 0030 00000000 0 30303030
6 7 0 0000 00000000 0 0

//--- flist.f
l1_pkg.sv
l2_req_if.sv
rr_arbiter.sv
store_buffer.sv
load_miss_unit.sv
l2_wb_master.sv
l1_mem_top.sv
tb_l1_mem.sv

//--- Bender.yml
package:
  name: l1_mem

sources:
  - files:
      - l1_pkg.sv
      - l2_req_if.sv
      - rr_arbiter.sv
      - store_buffer.sv
      - load_miss_unit.sv
      - l2_wb_master.sv
      - l1_mem_top.sv
  - target: test
    files:
      - tb_l1_mem.sv
